/* npc.f */
+incdir+logic
logic/npc_isa_pkg.sv
logic/npc_pipe_pkg.sv
logic/npc_fetch.sv
logic/npc_decode.sv
logic/npc_execute.sv
logic/npc_memory.sv
logic/npc_writeback.sv
logic/npc_top.sv
testbench/npc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the npc testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module npc_tb \
    -f npc.f \
    -o npc_sim

./obj_dir/npc_sim

/* testbench/npc_tb.sv */
`default_nettype none

`include "npc_config.svh"

module npc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import npc_isa_pkg::*;
    import npc_pipe_pkg::*;

    typedef struct packed {
        logic [63:0] pc;
        logic [4:0]  rd;
        logic        reg_write;
        logic [63:0] wdata;
    } expect_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        inst_req;
    logic [63:0] inst_addr;
    logic [31:0] inst;
    commit_t     commit;
    logic        halted;

    // program image and expected retire stream
    logic [31:0] prog_mem [64];
    logic [63:0] prog_len;
    expect_t     expect_q [$];
    logic [63:0] xr [32];
    logic [31:0] rng_state;

    npc_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_req  (inst_req),
        .inst_addr (inst_addr),
        .inst      (inst),
        .commit    (commit),
        .halted    (halted)
    );

    always #4 clk = ~clk;

    // --------------------------------------------------
    // instruction encoding
    // --------------------------------------------------
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [63:0] sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // past the end of the program everything is ebreak
    function automatic logic [31:0] fetch_word(input logic [63:0] addr);
        if ((addr >> 2) >= prog_len) begin
            return INST_EBREAK;
        end
        return prog_mem[addr[7:2]];
    endfunction

    // --------------------------------------------------
    // program and expected table
    // --------------------------------------------------
    task automatic draw_imm(output logic [11:0] imm);
        rng_state = xorshift32(rng_state);
        imm = rng_state[11:0];
    endtask

    task automatic append_word(input logic [31:0] word);
        prog_mem[prog_len[5:0]] = word;
        prog_len = prog_len + 64'd1;
    endtask

    task automatic expect_write(input logic [31:0] word, input logic [4:0] rd,
                                input logic [63:0] value);
        expect_t row;
        row.pc        = prog_len << 2;
        row.rd        = rd;
        row.reg_write = rd != 5'd0;
        row.wdata     = value;
        if (rd != 5'd0) begin
            xr[rd] = value;
        end
        expect_q.push_back(row);
        append_word(word);
    endtask

    // stores, branches and ebreak retire without a register write
    task automatic expect_no_write(input logic [31:0] word);
        expect_t row;
        row.pc        = prog_len << 2;
        row.rd        = '0;
        row.reg_write = 1'b0;
        row.wdata     = '0;
        expect_q.push_back(row);
        append_word(word);
    endtask

    task automatic build_program;
        logic [11:0] imm_a;
        logic [11:0] imm_b;
        logic [11:0] imm_c;
        for (int i = 0; i < 64; i++) begin
            prog_mem[i] = INST_EBREAK;
        end
        for (int i = 0; i < 32; i++) begin
            xr[i] = '0;
        end
        prog_len  = '0;
        rng_state = 32'h47fc_9826;
        draw_imm(imm_a);
        draw_imm(imm_b);
        draw_imm(imm_c);

        // dependent alu chain, forwarded from memory, writeback and the rf
        expect_write(i_type(OPC_OP_IMM, 3'b000, 5'd1, 5'd0, imm_a), 5'd1, sext12(imm_a));
        expect_write(i_type(OPC_OP_IMM, 3'b000, 5'd2, 5'd1, imm_b), 5'd2,
                     xr[1] + sext12(imm_b));
        expect_write(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 5'd3, xr[1] + xr[2]);
        expect_write(r_type(7'h20, 3'b000, 5'd4, 5'd3, 5'd1), 5'd4, xr[3] - xr[1]);
        expect_write(r_type(7'h00, 3'b111, 5'd5, 5'd4, 5'd2), 5'd5, xr[4] & xr[2]);
        expect_write(r_type(7'h00, 3'b110, 5'd6, 5'd5, 5'd3), 5'd6, xr[5] | xr[3]);
        expect_write(r_type(7'h00, 3'b100, 5'd7, 5'd6, 5'd4), 5'd7, xr[6] ^ xr[4]);
        expect_write(u_type(5'd8, 20'h12345), 5'd8, 64'h0000_0000_1234_5000);
        expect_write(u_type(5'd9, 20'h80001), 5'd9, 64'hffff_ffff_8000_1000);
        expect_write(r_type(7'h00, 3'b000, 5'd10, 5'd8, 5'd9), 5'd10, xr[8] + xr[9]);

        // x0 as destination, then as source
        expect_write(i_type(OPC_OP_IMM, 3'b000, 5'd0, 5'd10, imm_c), 5'd0, '0);
        expect_write(r_type(7'h00, 3'b000, 5'd11, 5'd0, 5'd10), 5'd11, xr[10]);

        // sd, ld and a load-use consumer
        expect_write(i_type(OPC_OP_IMM, 3'b000, 5'd12, 5'd0, 12'h040), 5'd12, 64'h40);
        expect_no_write(s_type(5'd12, 5'd10, 12'h008));
        expect_write(i_type(OPC_LOAD, 3'b011, 5'd13, 5'd12, 12'h008), 5'd13, xr[10]);
        expect_write(r_type(7'h00, 3'b000, 5'd14, 5'd13, 5'd11), 5'd14, xr[13] + xr[11]);

        // taken beq, two flushed slots
        expect_no_write(b_type(3'b000, 5'd1, 5'd1, 13'd12));
        append_word(i_type(OPC_OP_IMM, 3'b000, 5'd20, 5'd0, 12'h001));
        append_word(i_type(OPC_OP_IMM, 3'b000, 5'd21, 5'd0, 12'h002));
        expect_no_write(b_type(3'b001, 5'd1, 5'd1, 13'd8));
        expect_write(i_type(OPC_OP_IMM, 3'b000, 5'd15, 5'd0, 12'h005), 5'd15, 64'd5);
        expect_no_write(b_type(3'b001, 5'd15, 5'd0, 13'd12));
        append_word(i_type(OPC_OP_IMM, 3'b000, 5'd22, 5'd0, 12'h003));
        append_word(i_type(OPC_OP_IMM, 3'b000, 5'd23, 5'd0, 12'h004));
        expect_no_write(b_type(3'b000, 5'd15, 5'd0, 13'd8));

        // jal links pc+4
        expect_write(j_type(5'd16, 21'd12), 5'd16, (prog_len << 2) + 64'd4);
        append_word(i_type(OPC_OP_IMM, 3'b000, 5'd24, 5'd0, 12'h006));
        append_word(i_type(OPC_OP_IMM, 3'b000, 5'd25, 5'd0, 12'h007));
        expect_write(r_type(7'h00, 3'b000, 5'd17, 5'd16, 5'd14), 5'd17, xr[16] + xr[14]);
        expect_no_write(INST_EBREAK);
    endtask

    // --------------------------------------------------
    // checking
    // --------------------------------------------------
    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail at %0t ns: %s got 0x%h expected 0x%h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_first_fetch;
        int cycles;
        cycles = 0;
        while (!inst_req && cycles < 10) begin
            @(negedge clk);
            check_value("commit.valid", {63'd0, commit.valid}, 64'd0);
            cycles++;
        end
        if (!inst_req) begin
            report_failure("no instruction fetch request after reset was released");
        end
        check_value("inst_addr", inst_addr, `NPC_RESET_PC);
    endtask

    task automatic wait_commit(input int row);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!commit.valid && cycles < 50);
        if (!commit.valid) begin
            report_failure($sformatf("no commit for expected row %0d within 50 cycles", row));
        end
    endtask

    task automatic check_commit(input expect_t row);
        check_value("commit.pc", commit.pc, row.pc);
        check_value("commit.reg_write", {63'd0, commit.reg_write}, {63'd0, row.reg_write});
        if (row.reg_write) begin
            check_value("commit.rd", {59'd0, commit.rd}, {59'd0, row.rd});
            check_value("commit.wdata", commit.wdata, row.wdata);
        end
    endtask

    task automatic wait_halt;
        int cycles;
        cycles = 0;
        while (!halted && cycles < 10) begin
            @(negedge clk);
            check_value("commit.valid", {63'd0, commit.valid}, 64'd0);
            cycles++;
        end
        if (!halted) begin
            report_failure("halted did not rise after the ebreak committed");
        end
    endtask

    // --------------------------------------------------
    // instruction memory, one cycle read
    // --------------------------------------------------
    initial begin : imem_model
        logic        req_seen;
        logic [63:0] req_addr;
        inst = INST_EBREAK;
        forever begin
            @(negedge clk);
            req_seen = inst_req;
            req_addr = inst_addr;
            @(posedge clk);
            #1;
            if (req_seen) begin
                inst = fetch_word(req_addr);
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        build_program();
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_first_fetch();
        for (int i = 0; i < expect_q.size(); i++) begin
            wait_commit(i);
            check_commit(expect_q[i]);
        end

        // pipeline frozen after ebreak
        wait_halt();
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check_value("commit.valid", {63'd0, commit.valid}, 64'd0);
            check_value("halted", {63'd0, halted}, 64'd1);
        end

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/npc_top.sv */
`default_nettype none

module npc_top (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    output logic                      inst_req,
    output logic [63:0]               inst_addr,
    input  wire logic [31:0]          inst,
    output npc_pipe_pkg::commit_t     commit,
    output logic                      halted
);
    import npc_pipe_pkg::*;

    // --------------------------------------------------
    // handshakes and stage buses
    // --------------------------------------------------
    logic         ds_allowin;
    logic         es_allowin;
    logic         ms_allowin;
    logic         ws_allowin;
    logic         fs_to_ds_valid;
    logic         ds_to_es_valid;
    logic         es_to_ms_valid;
    logic         ms_to_ws_valid;
    fs_to_ds_t    fs_to_ds_bus;
    ds_to_es_t    ds_to_es_bus;
    es_to_ms_t    es_to_ms_bus;
    ms_to_ws_t    ms_to_ws_bus;

    // hazard, forwarding and redirect paths
    br_redirect_t br;
    rf_write_t    ms_fwd;
    rf_write_t    ws_to_rf;
    logic         es_load;
    logic [4:0]   es_load_rd;

    npc_fetch u_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .ds_allowin     (ds_allowin),
        .br             (br),
        .inst_req       (inst_req),
        .inst_addr      (inst_addr),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus)
    );

    npc_decode u_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .inst           (inst),
        .es_allowin     (es_allowin),
        .ds_allowin     (ds_allowin),
        .es_load_rd     (es_load_rd),
        .es_load        (es_load),
        .br             (br),
        .ws_to_rf       (ws_to_rf),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus)
    );

    npc_execute u_execute (
        .clk            (clk),
        .rst_n          (rst_n),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .ms_allowin     (ms_allowin),
        .es_allowin     (es_allowin),
        .ms_fwd         (ms_fwd),
        .ws_to_rf       (ws_to_rf),
        .es_load        (es_load),
        .es_load_rd     (es_load_rd),
        .br             (br),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus)
    );

    npc_memory u_memory (
        .clk            (clk),
        .rst_n          (rst_n),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .ws_allowin     (ws_allowin),
        .ms_allowin     (ms_allowin),
        .ms_fwd         (ms_fwd),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus)
    );

    npc_writeback u_writeback (
        .clk            (clk),
        .rst_n          (rst_n),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .ws_allowin     (ws_allowin),
        .ws_to_rf       (ws_to_rf),
        .commit         (commit),
        .halted         (halted)
    );

endmodule

`default_nettype wire

/* logic/npc_writeback.sv */
`default_nettype none

module npc_writeback (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    ms_to_ws_valid,
    input  wire npc_pipe_pkg::ms_to_ws_t ms_to_ws_bus,
    output logic                         ws_allowin,
    output npc_pipe_pkg::rf_write_t      ws_to_rf,
    output npc_pipe_pkg::commit_t        commit,
    output logic                         halted
);
    import npc_pipe_pkg::*;

    logic      ws_valid;
    ms_to_ws_t ws_bus;
    logic      retire;

    // retires every cycle until an ebreak has gone through
    assign ws_allowin = !halted;
    assign retire     = ws_valid && !halted;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ws_valid <= 1'b0;
            halted   <= 1'b0;
        end else begin
            if (ws_allowin) begin
                ws_valid <= ms_to_ws_valid;
            end
            if (retire && ws_bus.is_ebreak) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ws_allowin && ms_to_ws_valid) begin
            ws_bus <= ms_to_ws_bus;
        end
    end

    assign ws_to_rf.we    = retire && ws_bus.reg_write;
    assign ws_to_rf.waddr = ws_bus.rd;
    assign ws_to_rf.wdata = ws_bus.result;

    assign commit.valid     = retire;
    assign commit.pc        = ws_bus.pc;
    assign commit.rd        = ws_bus.rd;
    assign commit.reg_write = ws_bus.reg_write;
    assign commit.wdata     = ws_bus.result;

endmodule

`default_nettype wire

/* logic/npc_memory.sv */
`default_nettype none

`include "npc_config.svh"

module npc_memory (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    es_to_ms_valid,
    input  wire npc_pipe_pkg::es_to_ms_t es_to_ms_bus,
    input  wire logic                    ws_allowin,
    output logic                         ms_allowin,
    output npc_pipe_pkg::rf_write_t      ms_fwd,
    output logic                         ms_to_ws_valid,
    output npc_pipe_pkg::ms_to_ws_t      ms_to_ws_bus
);
    import npc_isa_pkg::*;
    import npc_pipe_pkg::*;

    localparam int DMEM_AW = $clog2(`NPC_DMEM_WORDS);

    logic      ms_valid;
    es_to_ms_t ms_bus;
    word_t     dmem [`NPC_DMEM_WORDS];
    word_t     load_data;

    assign ms_allowin = !ms_valid || ws_allowin;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_allowin && es_to_ms_valid) begin
            ms_bus <= es_to_ms_bus;
        end
    end

    // sd lands as the store enters the stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NPC_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ms_allowin && es_to_ms_valid && es_to_ms_bus.ctrl.mem_write) begin
            dmem[es_to_ms_bus.alu_result[3 +: DMEM_AW]] <= es_to_ms_bus.store_data;
        end
    end

    assign load_data = dmem[ms_bus.alu_result[3 +: DMEM_AW]];

    // load data is not ready in time for execute
    assign ms_fwd.we    = ms_valid && ms_bus.ctrl.reg_write && !ms_bus.ctrl.mem_read;
    assign ms_fwd.waddr = ms_bus.rd;
    assign ms_fwd.wdata = ms_bus.alu_result;

    assign ms_to_ws_valid = ms_valid;

    always_comb begin
        ms_to_ws_bus.pc        = ms_bus.pc;
        ms_to_ws_bus.reg_write = ms_bus.ctrl.reg_write;
        ms_to_ws_bus.is_ebreak = ms_bus.ctrl.is_ebreak;
        ms_to_ws_bus.rd        = ms_bus.rd;
        ms_to_ws_bus.result    = ms_bus.ctrl.mem_read ? load_data : ms_bus.alu_result;
    end

    // ld and sd only touch whole doublewords
    a_dword_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (es_to_ms_valid && ms_allowin
            && (es_to_ms_bus.ctrl.mem_read || es_to_ms_bus.ctrl.mem_write))
            |-> es_to_ms_bus.alu_result[2:0] == 3'b000);

endmodule

`default_nettype wire

/* logic/npc_execute.sv */
`default_nettype none

module npc_execute (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       ds_to_es_valid,
    input  wire npc_pipe_pkg::ds_to_es_t    ds_to_es_bus,
    input  wire logic                       ms_allowin,
    output logic                            es_allowin,
    input  wire npc_pipe_pkg::rf_write_t    ms_fwd,
    input  wire npc_pipe_pkg::rf_write_t    ws_to_rf,
    output logic                            es_load,
    output logic [4:0]                      es_load_rd,
    output npc_pipe_pkg::br_redirect_t      br,
    output logic                            es_to_ms_valid,
    output npc_pipe_pkg::es_to_ms_t         es_to_ms_bus
);
    import npc_isa_pkg::*;
    import npc_pipe_pkg::*;

    logic      es_valid;
    ds_to_es_t es_bus;
    word_t     src_a;
    word_t     src_b_reg;
    word_t     src_b;
    word_t     alu_out;
    logic      br_cond;

    assign es_allowin = !es_valid || ms_allowin;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_allowin && ds_to_es_valid) begin
            es_bus <= ds_to_es_bus;
        end
    end

    // --------------------------------------------------
    // forwarding and ALU
    // --------------------------------------------------
    // memory stage wins over writeback
    function automatic word_t fwd(reg_addr_t rs, word_t rf_val);
        if (rs != '0 && ms_fwd.we && ms_fwd.waddr == rs) begin
            return ms_fwd.wdata;
        end
        if (rs != '0 && ws_to_rf.we && ws_to_rf.waddr == rs) begin
            return ws_to_rf.wdata;
        end
        return rf_val;
    endfunction

    always_comb begin
        src_a     = fwd(es_bus.rs1, es_bus.rs1_val);
        src_b_reg = fwd(es_bus.rs2, es_bus.rs2_val);
        src_b     = es_bus.ctrl.use_imm ? es_bus.imm : src_b_reg;
        case (es_bus.ctrl.alu_op)
            ALU_SUB:    alu_out = src_a - src_b;
            ALU_AND:    alu_out = src_a & src_b;
            ALU_OR:     alu_out = src_a | src_b;
            ALU_XOR:    alu_out = src_a ^ src_b;
            ALU_PASS_B: alu_out = src_b;
            default:    alu_out = src_a + src_b;
        endcase
    end

    // --------------------------------------------------
    // branch resolution
    // --------------------------------------------------
    assign br_cond = es_bus.ctrl.is_jal
                  || (es_bus.ctrl.is_branch && ((src_a == src_b_reg) ^ es_bus.ctrl.branch_ne));

    // redirect fires as the item moves on to memory
    assign br.taken  = es_valid && ms_allowin && br_cond;
    assign br.target = es_bus.pc + es_bus.imm;

    assign es_load    = es_valid && es_bus.ctrl.mem_read;
    assign es_load_rd = es_bus.rd;

    assign es_to_ms_valid = es_valid;

    always_comb begin
        es_to_ms_bus.pc         = es_bus.pc;
        es_to_ms_bus.ctrl       = es_bus.ctrl;
        es_to_ms_bus.rd         = es_bus.rd;
        es_to_ms_bus.alu_result = es_bus.ctrl.is_jal ? es_bus.pc + 64'd4 : alu_out;
        es_to_ms_bus.store_data = src_b_reg;
    end

    // the slot behind a taken redirect arrives squashed
    a_br_valid: assert property (@(posedge clk) disable iff (!rst_n)
        br.taken |=> !es_valid);

endmodule

`default_nettype wire

/* logic/npc_decode.sv */
`default_nettype none

`include "npc_config.svh"

module npc_decode (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       fs_to_ds_valid,
    input  wire npc_pipe_pkg::fs_to_ds_t    fs_to_ds_bus,
    input  wire logic [31:0]                inst,
    input  wire logic                       es_allowin,
    output logic                            ds_allowin,
    input  wire logic [4:0]                 es_load_rd,
    input  wire logic                       es_load,
    input  wire npc_pipe_pkg::br_redirect_t br,
    input  wire npc_pipe_pkg::rf_write_t    ws_to_rf,
    output logic                            ds_to_es_valid,
    output npc_pipe_pkg::ds_to_es_t         ds_to_es_bus
);
    import npc_isa_pkg::*;

    logic        ds_valid;
    word_t       ds_pc;
    logic [31:0] ds_inst;
    word_t       rf [`NPC_NUM_REGS];

    ctrl_t       ctrl;
    word_t       imm;
    logic        use_rs1;
    logic        use_rs2;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    logic        load_use;
    logic        ds_ready_go;

    // --------------------------------------------------
    // stage register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ds_valid <= 1'b0;
        end else if (br.taken) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_allowin && fs_to_ds_valid) begin
            ds_pc   <= fs_to_ds_bus.pc;
            ds_inst <= inst;
        end
    end

    // --------------------------------------------------
    // decoder
    // --------------------------------------------------
    always_comb begin
        ctrl    = '0;
        imm     = '0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (ds_inst[6:0])
            OPC_OP: begin
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
                ctrl.reg_write = 1'b1;
                case (ds_inst[14:12])
                    3'b000:  ctrl.alu_op = ds_inst[30] ? ALU_SUB : ALU_ADD;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                // addi only
                use_rs1        = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = ds_inst[14:12] == 3'b000;
                imm            = {{52{ds_inst[31]}}, ds_inst[31:20]};
            end
            OPC_LUI: begin
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = {{32{ds_inst[31]}}, ds_inst[31:12], 12'b0};
            end
            OPC_LOAD: begin
                use_rs1        = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_read  = ds_inst[14:12] == 3'b011;
                ctrl.reg_write = ds_inst[14:12] == 3'b011;
                imm            = {{52{ds_inst[31]}}, ds_inst[31:20]};
            end
            OPC_STORE: begin
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = ds_inst[14:12] == 3'b011;
                imm            = {{52{ds_inst[31]}}, ds_inst[31:25], ds_inst[11:7]};
            end
            OPC_BRANCH: begin
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
                ctrl.is_branch = ds_inst[14:13] == 2'b00;
                ctrl.branch_ne = ds_inst[12];
                imm            = {{51{ds_inst[31]}}, ds_inst[31], ds_inst[7],
                                  ds_inst[30:25], ds_inst[11:8], 1'b0};
            end
            OPC_JAL: begin
                ctrl.is_jal    = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = {{43{ds_inst[31]}}, ds_inst[31], ds_inst[19:12],
                                  ds_inst[20], ds_inst[30:21], 1'b0};
            end
            OPC_SYSTEM: ctrl.is_ebreak = ds_inst == INST_EBREAK;
            default: ;
        endcase
        // x0 is never a destination
        if (ds_inst[11:7] == 5'd0) begin
            ctrl.reg_write = 1'b0;
        end
    end

    assign rs1 = use_rs1 ? ds_inst[19:15] : '0;
    assign rs2 = use_rs2 ? ds_inst[24:20] : '0;
    assign rd  = ds_inst[11:7];

    // --------------------------------------------------
    // register file
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (ws_to_rf.we && ws_to_rf.waddr != '0) begin
            rf[ws_to_rf.waddr] <= ws_to_rf.wdata;
        end
    end

    // write-through covers a producer three ahead
    function automatic word_t rf_read(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (ws_to_rf.we && ws_to_rf.waddr == addr) begin
            return ws_to_rf.wdata;
        end
        return rf[addr];
    endfunction

    // load in execute feeding this item
    assign load_use    = es_load && es_load_rd != 5'd0
                      && (rs1 == es_load_rd || rs2 == es_load_rd);
    assign ds_ready_go = !load_use;
    assign ds_allowin  = !ds_valid || (ds_ready_go && es_allowin);

    assign ds_to_es_valid = ds_valid && ds_ready_go && !br.taken;

    always_comb begin
        ds_to_es_bus.pc      = ds_pc;
        ds_to_es_bus.ctrl    = ctrl;
        ds_to_es_bus.rs1     = rs1;
        ds_to_es_bus.rs2     = rs2;
        ds_to_es_bus.rd      = rd;
        ds_to_es_bus.rs1_val = rf_read(rs1);
        ds_to_es_bus.rs2_val = rf_read(rs2);
        ds_to_es_bus.imm     = imm;
    end

    // no retiring writer ever targets x0
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ws_to_rf.we |-> ws_to_rf.waddr != '0);

endmodule

`default_nettype wire

/* logic/npc_fetch.sv */
`default_nettype none

`include "npc_config.svh"

module npc_fetch (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       ds_allowin,
    input  wire npc_pipe_pkg::br_redirect_t br,
    output logic                            inst_req,
    output logic [63:0]                     inst_addr,
    output logic                            fs_to_ds_valid,
    output npc_pipe_pkg::fs_to_ds_t         fs_to_ds_bus
);
    import npc_isa_pkg::*;

    logic  started;
    logic  fs_valid;
    logic  fs_load;
    word_t seq_pc;
    word_t fs_pc;

    // a redirect drops the held item so fetch may always load
    assign fs_load  = started && (br.taken || !fs_valid || ds_allowin);
    assign inst_req = started;

    // a held item re-requests its own pc to keep inst in step
    always_comb begin
        if (br.taken) begin
            inst_addr = br.target;
        end else if (fs_load) begin
            inst_addr = seq_pc;
        end else begin
            inst_addr = fs_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            started  <= 1'b0;
            fs_valid <= 1'b0;
            seq_pc   <= `NPC_RESET_PC;
        end else begin
            started <= 1'b1;
            if (fs_load) begin
                fs_valid <= 1'b1;
                seq_pc   <= inst_addr + 64'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fs_load) begin
            fs_pc <= inst_addr;
        end
    end

    assign fs_to_ds_valid  = fs_valid;
    assign fs_to_ds_bus.pc = fs_pc;

    // redirect targets come from execute and must stay word aligned
    a_fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        inst_req |-> inst_addr[1:0] == 2'b00);

endmodule

`default_nettype wire

/* logic/npc_pipe_pkg.sv */
`default_nettype none

package npc_pipe_pkg;

    // --------------------------------------------------
    // stage buses
    // --------------------------------------------------
    typedef struct packed {
        npc_isa_pkg::word_t pc;
    } fs_to_ds_t;

    // unused source fields are zeroed by decode
    typedef struct packed {
        npc_isa_pkg::word_t     pc;
        npc_isa_pkg::ctrl_t     ctrl;
        npc_isa_pkg::reg_addr_t rs1;
        npc_isa_pkg::reg_addr_t rs2;
        npc_isa_pkg::reg_addr_t rd;
        npc_isa_pkg::word_t     rs1_val;
        npc_isa_pkg::word_t     rs2_val;
        npc_isa_pkg::word_t     imm;
    } ds_to_es_t;

    typedef struct packed {
        npc_isa_pkg::word_t     pc;
        npc_isa_pkg::ctrl_t     ctrl;
        npc_isa_pkg::reg_addr_t rd;
        npc_isa_pkg::word_t     alu_result;
        npc_isa_pkg::word_t     store_data;
    } es_to_ms_t;

    typedef struct packed {
        npc_isa_pkg::word_t     pc;
        logic                   reg_write;
        logic                   is_ebreak;
        npc_isa_pkg::reg_addr_t rd;
        npc_isa_pkg::word_t     result;
    } ms_to_ws_t;

    // --------------------------------------------------
    // side channels
    // --------------------------------------------------
    // register file write, also the writeback forwarding source
    typedef struct packed {
        logic                   we;
        npc_isa_pkg::reg_addr_t waddr;
        npc_isa_pkg::word_t     wdata;
    } rf_write_t;

    typedef struct packed {
        logic               taken;
        npc_isa_pkg::word_t target;
    } br_redirect_t;

    typedef struct packed {
        logic                   valid;
        npc_isa_pkg::word_t     pc;
        npc_isa_pkg::reg_addr_t rd;
        logic                   reg_write;
        npc_isa_pkg::word_t     wdata;
    } commit_t;

endpackage

`default_nettype wire

/* logic/npc_isa_pkg.sv */
`default_nettype none

`include "npc_config.svh"

package npc_isa_pkg;

    typedef logic [63:0] word_t;
    typedef logic [$clog2(`NPC_NUM_REGS)-1:0] reg_addr_t;

    // --------------------------------------------------
    // major opcodes of the supported subset
    // --------------------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [31:0] INST_EBREAK = 32'h0010_0073;

    // pass-b hands the immediate straight through for lui
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    is_branch;
        logic    branch_ne;
        logic    is_jal;
        logic    is_ebreak;
    } ctrl_t;

endpackage

`default_nettype wire

/* logic/npc_config.svh */
`ifndef NPC_CONFIG_SVH
`define NPC_CONFIG_SVH

// address of the first fetch after reset
`define NPC_RESET_PC 64'h0000_0000_0000_0000

// data memory size in doublewords
`define NPC_DMEM_WORDS 256

// architectural integer registers
`define NPC_NUM_REGS 32

`endif
